/* list.f */
+incdir+verilog
verilog/par_pkg.sv
verilog/iter_alloc.sv
verilog/loop_core.sv
verilog/result_reducer.sv
verilog/par_top.sv
tb/par_tb.sv

/* Bender.yml */
package:
  name: par_dispatch

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/par_pkg.sv
      - verilog/iter_alloc.sv
      - verilog/loop_core.sv
      - verilog/result_reducer.sv
      - verilog/par_top.sv
  - target: test
    files:
      - tb/par_tb.sv

/* tb/par_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "par_macros.svh"

module par_tb;
	import par_pkg::*;

	localparam int N_LOOPS = 8;
	localparam int LOOP_MARGIN = 40;

	logic                  clk;
	logic                  arst_n;
	loop_cmd_t             cmd;
	logic                  cmd_valid;
	logic                  cmd_ready;
	result_t               res;
	logic                  res_valid;
	logic [`PAR_VAL_W-1:0] sum;
	logic [`PAR_CNT_W-1:0] count;
	logic                  done;

	integer    seed = 32'h61b0;
	int        errors = 0;
	int        checks = 0;
	int        cycles = 0;
	int        limit = 1000;
	loop_cmd_t cmds [N_LOOPS];

	// Model state of the loop in flight
	logic                   loop_active = 1'b0;
	loop_cmd_t              cur;
	bit                     seen [0:(1 << `PAR_CNT_W) - 1];
	logic [`PAR_N_CORE-1:0] cores_seen;

	par_top dut (
		.clk(clk),
		.arst_n(arst_n),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.res(res),
		.res_valid(res_valid),
		.sum(sum),
		.count(count),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// start + seq * stride, wrapping at the index width
	function automatic logic [`PAR_IDX_W-1:0] expected_index(input loop_cmd_t c,
			input logic [`PAR_CNT_W-1:0] seq);
		int full;
		full = int'(c.start) + int'(seq) * int'($signed(c.stride));
		return `PAR_IDX_W'(full);
	endfunction

	function automatic logic [`PAR_VAL_W-1:0] index_square(input logic [`PAR_IDX_W-1:0] idx);
		logic [`PAR_VAL_W-1:0] wide;
		wide = `PAR_VAL_W'(idx);
		return wide * wide;
	endfunction

	// Watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("Timeout: run hung waiting for done after %0d cycles", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// Result monitor, sampled mid-cycle
	always @(negedge clk) begin : monitor
		logic [`PAR_IDX_W-1:0] exp_idx;
		if (res_valid) begin
			if (!loop_active) begin
				errors++;
				$display("ERROR at %0t: res_valid high with no loop running", $time);
			end else if (res.seq >= cur.count) begin
				errors++;
				$display("ERROR at %0t: seq %0d is not below count %0d", $time, res.seq,
					cur.count);
			end else begin
				if (seen[res.seq]) begin
					errors++;
					$display("ERROR at %0t: seq %0d delivered twice", $time, res.seq);
				end
				seen[res.seq] = 1'b1;
				cores_seen[res.core] = 1'b1;
				exp_idx = expected_index(cur, res.seq);
				check("res.index", res.index, exp_idx);
				check("res.square", res.square, index_square(exp_idx));
			end
		end
	end

	task automatic run_loop(input int n);
		int                    err_before;
		logic [`PAR_VAL_W-1:0] model_sum;
		err_before = errors;
		model_sum = '0;
		for (int s = 0; s < cmds[n].count; s++) begin
			model_sum = model_sum + index_square(expected_index(cmds[n], `PAR_CNT_W'(s)));
		end
		@(posedge clk);
		#2;
		for (int s = 0; s < (1 << `PAR_CNT_W); s++) begin
			seen[s] = 1'b0;
		end
		cores_seen = '0;
		cur = cmds[n];
		loop_active = 1'b1;
		cmd = cmds[n];
		cmd_valid = 1'b1;
		@(negedge clk);
		check("cmd_ready", cmd_ready, 1'b1);
		@(posedge clk);
		#2;
		cmd_valid = 1'b0;
		@(negedge clk);
		while (!done) begin
			@(negedge clk);
		end
		check("count", count, cur.count);
		check("sum", sum, model_sum);
		for (int s = 0; s < cur.count; s++) begin
			if (!seen[s]) begin
				errors++;
				$display("ERROR: seq %0d never delivered in loop %0d", s, n);
			end
		end
		// All four cores request together, so two or more iterations spread out
		if (cur.count >= 2 && $countones(cores_seen) < 2) begin
			errors++;
			$display("ERROR: loop %0d served by a single core only", n);
		end
		loop_active = 1'b0;
		$display("loop %0d start=%h stride=%0d count=%0d cores=%b: %s", n, cur.start,
			$signed(cur.stride), cur.count, cores_seen,
			(errors == err_before) ? "ok" : "errors");
	endtask

	initial begin
		int s;
		int budget;
		arst_n = 1'b0;
		cmd = '0;
		cmd_valid = 1'b0;

		// Random commands, count 1 and a negative stride forced
		budget = 5 + 10;
		for (int n = 0; n < N_LOOPS; n++) begin
			s = $random(seed) % 8;
			cmds[n].start = `PAR_IDX_W'($random(seed));
			cmds[n].stride = `PAR_IDX_W'(s);
			cmds[n].count = `PAR_CNT_W'(1 + ($unsigned($random(seed)) % 40));
			if (n == 1) begin
				s = -1 - int'($unsigned($random(seed)) % 7);
				cmds[n].stride = `PAR_IDX_W'(s);
			end
			if (n == 2) begin
				cmds[n].count = `PAR_CNT_W'(1);
			end
			budget = budget + cmds[n].count * (`PAR_IDX_W + 8) + LOOP_MARGIN;
		end
		limit = budget;

		repeat (5) @(posedge clk);
		#2;
		arst_n = 1'b1;

		// Quiet after reset
		repeat (4) begin
			@(negedge clk);
			check("done", done, 1'b1);
			check("cmd_ready", cmd_ready, 1'b1);
			check("res_valid", res_valid, 1'b0);
		end

		for (int n = 0; n < N_LOOPS; n++) begin
			run_loop(n);
		end

		$display("%0d loops, %0d checks, %0d errors", N_LOOPS, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/par_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "par_macros.svh"

module par_top (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire par_pkg::loop_cmd_t cmd,
	input  wire logic               cmd_valid,
	output logic                    cmd_ready,
	output par_pkg::result_t        res,
	output logic                    res_valid,
	output logic [`PAR_VAL_W-1:0]   sum,
	output logic [`PAR_CNT_W-1:0]   count,
	output logic                    done
);
	import par_pkg::*;

	logic [`PAR_N_CORE-1:0] req;
	iter_grant_t            grant [`PAR_N_CORE];
	logic                   exhausted;
	result_t                put_data [`PAR_N_CORE];
	logic [`PAR_N_CORE-1:0] put_valid;
	logic [`PAR_N_CORE-1:0] credit;
	logic [`PAR_N_CORE-1:0] core_idle;
	logic                   red_empty;
	logic                   clear;

	// Accepting a command also clears the sum and count
	assign clear = cmd_valid && cmd_ready;

	iter_alloc u_alloc (
		.clk,
		.arst_n,
		.cmd,
		.cmd_valid,
		.cmd_ready,
		.req,
		.grant,
		.exhausted,
		.done
	);

	for (genvar i = 0; i < `PAR_N_CORE; i++) begin : g_core
		loop_core #(
			.CORE_ID(i)
		) u_core (
			.clk,
			.arst_n,
			.grant(grant[i]),
			.exhausted,
			.req(req[i]),
			.put_data(put_data[i]),
			.put_valid(put_valid[i]),
			.credit(credit[i]),
			.idle(core_idle[i])
		);
	end

	result_reducer u_reducer (
		.clk,
		.arst_n,
		.put_data,
		.put_valid,
		.credit,
		.clear,
		.res,
		.res_valid,
		.sum,
		.count,
		.empty(red_empty)
	);

	// Loop is finished once nothing is left in any core or buffer
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done <= 1'b1;
		end else if (clear) begin
			done <= 1'b0;
		end else if (exhausted && (&core_idle) && red_empty && !res_valid) begin
			done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/result_reducer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "par_macros.svh"

module result_reducer (
	input  wire logic                   clk,
	input  wire logic                   arst_n,
	input  wire par_pkg::result_t       put_data [`PAR_N_CORE],
	input  wire logic [`PAR_N_CORE-1:0] put_valid,
	output logic [`PAR_N_CORE-1:0]      credit,
	input  wire logic                   clear,
	output par_pkg::result_t            res,
	output logic                        res_valid,
	output logic [`PAR_VAL_W-1:0]       sum,
	output logic [`PAR_CNT_W-1:0]       count,
	output logic                        empty
);
	import par_pkg::*;

	localparam int SEL_W = $clog2(`PAR_N_CORE);
	localparam int PTR_W = (`PAR_CREDITS > 1) ? $clog2(`PAR_CREDITS) : 1;
	localparam int OCC_W = $clog2(`PAR_CREDITS + 1);

	result_t                mem [`PAR_N_CORE][`PAR_CREDITS];
	logic [PTR_W-1:0]       wr_ptr [`PAR_N_CORE];
	logic [PTR_W-1:0]       rd_ptr [`PAR_N_CORE];
	logic [OCC_W-1:0]       occ [`PAR_N_CORE];
	logic [`PAR_N_CORE-1:0] nonempty;
	logic [`PAR_N_CORE-1:0] pop_vec;
	logic [SEL_W-1:0]       last;
	logic [SEL_W-1:0]       cand;
	logic [SEL_W-1:0]       pick;
	logic                   pick_valid;
	result_t                head;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(`PAR_CREDITS - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// Round robin, starting after the core served last
	always_comb begin
		for (int i = 0; i < `PAR_N_CORE; i++) begin
			nonempty[i] = (occ[i] != '0);
		end
		pick_valid = 1'b0;
		pick       = last;
		cand       = last;
		for (int k = 1; k <= `PAR_N_CORE; k++) begin
			cand = SEL_W'((int'(last) + k) % `PAR_N_CORE);
			if (!pick_valid && nonempty[cand]) begin
				pick_valid = 1'b1;
				pick       = cand;
			end
		end
		for (int i = 0; i < `PAR_N_CORE; i++) begin
			pop_vec[i] = pick_valid && (pick == SEL_W'(i));
		end
		head = mem[pick][rd_ptr[pick]];
	end

	assign empty = (nonempty == '0);

	always_ff @(posedge clk) begin
		for (int i = 0; i < `PAR_N_CORE; i++) begin
			if (put_valid[i]) begin
				mem[i][wr_ptr[i]] <= put_data[i];
			end
		end
		if (pick_valid) begin
			res <= head;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `PAR_N_CORE; i++) begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				occ[i]    <= '0;
			end
			last      <= SEL_W'(`PAR_N_CORE - 1);
			res_valid <= 1'b0;
			credit    <= '0;
		end else begin
			res_valid <= pick_valid;
			// Freed entry goes back as a credit alongside res_valid
			credit    <= pop_vec;
			if (pick_valid) begin
				last <= pick;
			end
			for (int i = 0; i < `PAR_N_CORE; i++) begin
				if (put_valid[i]) begin
					wr_ptr[i] <= ptr_inc(wr_ptr[i]);
				end
				if (pop_vec[i]) begin
					rd_ptr[i] <= ptr_inc(rd_ptr[i]);
				end
				if (put_valid[i] && !pop_vec[i]) begin
					occ[i] <= occ[i] + 1'b1;
				end else if (!put_valid[i] && pop_vec[i]) begin
					occ[i] <= occ[i] - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum   <= '0;
			count <= '0;
		end else if (clear) begin
			sum   <= '0;
			count <= '0;
		end else if (pick_valid) begin
			sum   <= sum + head.square;
			count <= count + 1'b1;
		end
	end

	for (genvar i = 0; i < `PAR_N_CORE; i++) begin : g_chk
		a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
			put_valid[i] |-> (occ[i] < OCC_W'(`PAR_CREDITS)));
	end

endmodule

`default_nettype wire

/* verilog/loop_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "par_macros.svh"

module loop_core #(
	parameter int CORE_ID = 0
) (
	input  wire logic                 clk,
	input  wire logic                 arst_n,
	input  wire par_pkg::iter_grant_t grant,
	input  wire logic                 exhausted,
	output logic                      req,
	output par_pkg::result_t          put_data,
	output logic                      put_valid,
	input  wire logic                 credit,
	output logic                      idle
);
	import par_pkg::*;

	localparam int BIT_W = $clog2(`PAR_IDX_W);
	localparam int CRD_W = $clog2(`PAR_CREDITS + 1);

	core_state_t           state;
	logic [`PAR_IDX_W-1:0] index_q;
	logic [`PAR_CNT_W-1:0] seq_q;
	logic [`PAR_VAL_W-1:0] acc;
	logic [`PAR_VAL_W-1:0] mcand;
	logic [`PAR_IDX_W-1:0] mplier;
	logic [BIT_W-1:0]      bit_cnt;
	logic [CRD_W-1:0]      credits;

	assign req       = (state == CORE_REQ);
	assign idle      = (state == CORE_REQ) || (state == CORE_IDLE);
	assign put_valid = (state == CORE_SEND) && (credits != '0);

	always_comb begin
		put_data.core   = 2'(CORE_ID);
		put_data.seq    = seq_q;
		put_data.index  = index_q;
		put_data.square = acc;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= CORE_IDLE;
			bit_cnt <= '0;
		end else begin
			case (state)
				CORE_IDLE: begin
					// A new loop shows up as exhausted dropping
					if (!exhausted) begin
						state <= CORE_REQ;
					end
				end
				CORE_REQ: begin
					if (grant.valid) begin
						state   <= CORE_MUL;
						bit_cnt <= '0;
					end else if (exhausted) begin
						state <= CORE_IDLE;
					end
				end
				CORE_MUL: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BIT_W'(`PAR_IDX_W - 1)) begin
						state <= CORE_SEND;
					end
				end
				CORE_SEND: begin
					if (put_valid) begin
						state <= CORE_REQ;
					end
				end
				default: state <= CORE_IDLE;
			endcase
		end
	end

	// Shift-add square, one multiplier bit per cycle
	always_ff @(posedge clk) begin
		if ((state == CORE_REQ) && grant.valid) begin
			index_q <= grant.index;
			seq_q   <= grant.seq;
			acc     <= '0;
			mcand   <= `PAR_VAL_W'(grant.index);
			mplier  <= grant.index;
		end else if (state == CORE_MUL) begin
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	// Credits start full; reducer returns one per freed entry
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= CRD_W'(`PAR_CREDITS);
		end else if (credit && !put_valid) begin
			credits <= credits + 1'b1;
		end else if (!credit && put_valid) begin
			credits <= credits - 1'b1;
		end
	end

	a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= CRD_W'(`PAR_CREDITS));

	// Shift-add result must match a plain multiply when it leaves the core
	a_square_ok: assert property (@(posedge clk) disable iff (!arst_n)
		put_valid |-> (acc == `PAR_VAL_W'(index_q) * `PAR_VAL_W'(index_q)));

endmodule

`default_nettype wire

/* verilog/iter_alloc.sv */
`timescale 1ns/1ps
`default_nettype none
`include "par_macros.svh"

module iter_alloc (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire par_pkg::loop_cmd_t      cmd,
	input  wire logic                    cmd_valid,
	output logic                         cmd_ready,
	input  wire logic [`PAR_N_CORE-1:0]  req,
	output par_pkg::iter_grant_t         grant [`PAR_N_CORE],
	output logic                         exhausted,
	input  wire logic                    done
);
	import par_pkg::*;

	alloc_state_t          state;
	logic [`PAR_IDX_W-1:0] start_q;
	logic [`PAR_IDX_W-1:0] stride_q;
	logic [`PAR_CNT_W-1:0] count_q;
	logic [`PAR_CNT_W-1:0] base_q;
	logic [`PAR_CNT_W:0]   rank [`PAR_N_CORE];
	logic [`PAR_CNT_W:0]   seq_ext [`PAR_N_CORE];
	logic [`PAR_N_CORE-1:0] granted;
	logic [`PAR_CNT_W:0]   n_grant;
	logic [`PAR_CNT_W:0]   base_next;
	logic                  accept;

	assign cmd_ready = (state == ALLOC_IDLE) && done;
	assign accept    = cmd_valid && cmd_ready;
	assign exhausted = (state == ALLOC_IDLE);

	// Prefix rank: i-th requester in core order gets base + i
	always_comb begin
		rank[0] = '0;
		for (int i = 1; i < `PAR_N_CORE; i++) begin
			rank[i] = rank[i-1] + req[i-1];
		end
		n_grant = '0;
		for (int i = 0; i < `PAR_N_CORE; i++) begin
			seq_ext[i] = {1'b0, base_q} + rank[i];
			granted[i] = (state == ALLOC_RUN) && req[i] && (seq_ext[i] < {1'b0, count_q});
			grant[i].valid = granted[i];
			grant[i].seq   = seq_ext[i][`PAR_CNT_W-1:0];
			// Index wraps modulo 2^PAR_IDX_W, so signed stride works unchanged
			grant[i].index = start_q + `PAR_IDX_W'(seq_ext[i]) * stride_q;
			if (granted[i]) begin
				n_grant = n_grant + 1'b1;
			end
		end
		base_next = {1'b0, base_q} + n_grant;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ALLOC_IDLE;
			count_q <= '0;
			base_q  <= '0;
		end else if (accept) begin
			state   <= ALLOC_RUN;
			count_q <= cmd.count;
			base_q  <= '0;
		end else if (state == ALLOC_RUN) begin
			base_q <= base_next[`PAR_CNT_W-1:0];
			if (base_next >= {1'b0, count_q}) begin
				state <= ALLOC_IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			start_q  <= cmd.start;
			stride_q <= cmd.stride;
		end
	end

	a_base_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		base_q <= count_q);

	// While the subsystem reports done the allocator must be idle and silent
	a_no_grant_idle: assert property (@(posedge clk) disable iff (!arst_n)
		done |-> (granted == '0));

endmodule

`default_nettype wire

/* verilog/par_pkg.sv */
`default_nettype none
`include "par_macros.svh"

package par_pkg;

	// One fork command
	typedef struct packed {
		logic [`PAR_IDX_W-1:0] start;
		logic [`PAR_IDX_W-1:0] stride;  // two's complement
		logic [`PAR_CNT_W-1:0] count;
	} loop_cmd_t;

	// Allocator answer to one core
	typedef struct packed {
		logic                  valid;
		logic [`PAR_IDX_W-1:0] index;
		logic [`PAR_CNT_W-1:0] seq;
	} iter_grant_t;

	// Core result toward the reducer
	typedef struct packed {
		logic [1:0]            core;
		logic [`PAR_CNT_W-1:0] seq;
		logic [`PAR_IDX_W-1:0] index;
		logic [`PAR_VAL_W-1:0] square;
	} result_t;

	typedef enum logic [1:0] {CORE_REQ, CORE_MUL, CORE_SEND, CORE_IDLE} core_state_t;
	typedef enum logic {ALLOC_IDLE, ALLOC_RUN} alloc_state_t;

endpackage

`default_nettype wire

/* verilog/par_macros.svh */
`ifndef PAR_MACROS_SVH
`define PAR_MACROS_SVH

// Number of worker cores sharing the iteration counter
`define PAR_N_CORE 4

// Index and stride width
`define PAR_IDX_W 16
// Iteration count and sequence number width
`define PAR_CNT_W 12
// Square and running sum width
`define PAR_VAL_W 32
// Reducer buffer depth per core, also the initial credit count
`define PAR_CREDITS 2

`endif
